// ==== Bender.yml ====
package:
  name: fpu_cmp

sources:
  - source/fpu_pkg.sv
  - source/fpu_lane.sv
  - source/fpu_both.sv
  - source/fpu_exc_acc.sv
  - source/fpu_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/fpu_tb.sv

// ==== flist.f ====
+incdir+tb
source/fpu_pkg.sv
source/fpu_lane.sv
source/fpu_both.sv
source/fpu_exc_acc.sv
source/fpu_top.sv
tb/fpu_tb.sv

// ==== source/fpu_both.sv ====
// fpu paired lane datapath
`timescale 1ns/100ps
`default_nettype none

module fpu_both #(
  parameter int unsigned PIPE_OUT_REG = 1
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         in_valid,
  input  fpu_pkg::fpu_op_e             in_op,
  input  fpu_pkg::fpu_word_u           in_a,
  input  fpu_pkg::fpu_word_u           in_b,
  output logic                         out_valid,
  output fpu_pkg::fpu_word_u           out_data,
  output logic [2*fpu_pkg::FLAG_W-1:0] out_flags,
  output logic                         out_invalid
);
  import fpu_pkg::*;

  localparam int DEPTH = 2 + PIPE_OUT_REG;

  // --------------------
  // ordering helpers
  function automatic logic [FLAG_W-1:0] order_flags(
    input logic nan_a,
    input logic nan_b,
    input logic zero_both,
    input logic sign_a,
    input logic sign_b,
    input logic mag_lt,
    input logic mag_eq
  );
    logic [FLAG_W-1:0] f;
    f = '0;
    if (nan_a || nan_b) begin
      f[FLG_UO] = 1'b1;
    end else if (zero_both || (sign_a == sign_b && mag_eq)) begin
      f[FLG_EQ] = 1'b1;
    end else if (sign_a != sign_b) begin
      f[FLG_LT] = sign_a;
      f[FLG_GT] = sign_b;
    end else begin
      f[FLG_LT] = mag_lt ^ sign_a;  // reversed when both negative.
      f[FLG_GT] = ~mag_lt ^ sign_a;
    end
    return f;
  endfunction

  // min/max choice; -0 sits below +0 here, unlike the compare flags
  function automatic logic pick_b(
    input logic [FLAG_W-1:0] f,
    input logic              nan_a,
    input logic              nan_b,
    input logic              zero_both,
    input logic              sign_a,
    input logic              sign_b,
    input logic              want_max
  );
    logic a_lt;
    logic a_gt;
    a_lt = zero_both ? (sign_a && !sign_b) : f[FLG_LT];
    a_gt = zero_both ? (!sign_a && sign_b) : f[FLG_GT];
    return nan_a || (!nan_b && (want_max ? a_lt : a_gt));
  endfunction

  // --------------------
  // lanes and stage 1
  logic              frac_nz_a, frac_nz_b;
  logic              h_mag_lt, h_mag_eq, h_sign_a, h_sign_b;
  logic              h_nan_a, h_nan_b, h_zero_a, h_zero_b;
  logic              h_dnan_a, h_dnan_b, h_dzero_a, h_dzero_b;
  logic [LANE_W-1:0] h_res;
  logic              l_mag_lt, l_mag_eq, l_sign_a, l_sign_b;
  logic              l_nan_a, l_nan_b, l_zero_a, l_zero_b;
  logic [LANE_W-1:0] l_res;
  logic [DEPTH-1:0]  v_q;
  fpu_op_e           op_q [DEPTH];
  fpu_word_u         s1_a, s1_b;

  fpu_lane #(.HIGH(1'b1)) hi_lane (
    .clk(clk), .rst(rst), .in_valid(in_valid), .in_op(in_op),
    .a(in_a.s.hi), .b(in_b.s.hi),
    .lo_frac_nz_a(frac_nz_a), .lo_frac_nz_b(frac_nz_b),
    .lane_frac_nz_a(), .lane_frac_nz_b(),
    .st_mag_lt(h_mag_lt), .st_mag_eq(h_mag_eq),
    .st_sign_a(h_sign_a), .st_sign_b(h_sign_b),
    .st_nan_a(h_nan_a), .st_nan_b(h_nan_b),
    .st_zero_a(h_zero_a), .st_zero_b(h_zero_b),
    .st_dnan_a(h_dnan_a), .st_dnan_b(h_dnan_b),
    .st_dzero_a(h_dzero_a), .st_dzero_b(h_dzero_b),
    .st_res(h_res)
  );

  fpu_lane #(.HIGH(1'b0)) lo_lane (
    .clk(clk), .rst(rst), .in_valid(in_valid), .in_op(in_op),
    .a(in_a.s.lo), .b(in_b.s.lo),
    .lo_frac_nz_a(1'b0), .lo_frac_nz_b(1'b0),
    .lane_frac_nz_a(frac_nz_a), .lane_frac_nz_b(frac_nz_b),
    .st_mag_lt(l_mag_lt), .st_mag_eq(l_mag_eq),
    .st_sign_a(l_sign_a), .st_sign_b(l_sign_b),
    .st_nan_a(l_nan_a), .st_nan_b(l_nan_b),
    .st_zero_a(l_zero_a), .st_zero_b(l_zero_b),
    .st_dnan_a(), .st_dnan_b(),
    .st_dzero_a(), .st_dzero_b(),
    .st_res(l_res)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      v_q <= '0;
    end else begin
      v_q <= {v_q[DEPTH-2:0], in_valid};
    end
  end

  always_ff @(posedge clk) begin
    op_q[0] <= in_op;
    for (int i = 1; i < DEPTH; i++) begin
      op_q[i] <= op_q[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      s1_a <= in_a;  // min/max picks from these.
      s1_b <= in_b;
    end
  end

  // --------------------
  // stage 2 ordering
  logic [FLAG_W-1:0] hi_f, lo_f, d_f;
  logic              is_max, hi_pick, lo_pick, d_pick, s_nan_any, d_nan_any;
  fpu_word_u         res;
  logic              inv;

  assign hi_f = order_flags(h_nan_a, h_nan_b, h_zero_a && h_zero_b,
                            h_sign_a, h_sign_b, h_mag_lt, h_mag_eq);
  assign lo_f = order_flags(l_nan_a, l_nan_b, l_zero_a && l_zero_b,
                            l_sign_a, l_sign_b, l_mag_lt, l_mag_eq);
  assign d_f  = order_flags(h_dnan_a, h_dnan_b, h_dzero_a && h_dzero_b, h_sign_a, h_sign_b,
                            h_mag_lt || (h_mag_eq && l_mag_lt), h_mag_eq && l_mag_eq);

  assign is_max  = op_q[0] inside {OP_MAX_S, OP_MAX_D};
  assign hi_pick = pick_b(hi_f, h_nan_a, h_nan_b, h_zero_a && h_zero_b,
                          h_sign_a, h_sign_b, is_max);
  assign lo_pick = pick_b(lo_f, l_nan_a, l_nan_b, l_zero_a && l_zero_b,
                          l_sign_a, l_sign_b, is_max);
  assign d_pick  = pick_b(d_f, h_dnan_a, h_dnan_b, h_dzero_a && h_dzero_b,
                          h_sign_a, h_sign_b, is_max);

  assign s_nan_any = h_nan_a || h_nan_b || l_nan_a || l_nan_b;
  assign d_nan_any = h_dnan_a || h_dnan_b;

  always_comb begin
    res = '0;
    inv = 1'b0;
    case (op_q[0])
      OP_ABS, OP_NEG: begin
        res.s.hi = h_res;
        res.s.lo = l_res;
      end
      OP_MAX_S, OP_MIN_S: begin
        res.s.hi = (h_nan_a && h_nan_b) ? fpu_single_t'(h_res) :
                   (hi_pick ? s1_b.s.hi : s1_a.s.hi);
        res.s.lo = (l_nan_a && l_nan_b) ? fpu_single_t'(l_res) :
                   (lo_pick ? s1_b.s.lo : s1_a.s.lo);
        inv = s_nan_any;
      end
      OP_MAX_D, OP_MIN_D: begin
        res.d = (h_dnan_a && h_dnan_b) ? fpu_double_t'(QNAN_D) :
                (d_pick ? s1_b.d : s1_a.d);
        inv = d_nan_any;
      end
      OP_CMP_S: inv = s_nan_any;
      OP_CMP_D: inv = d_nan_any;
      default: inv = 1'b0;
    endcase
  end

  fpu_word_u         s2_res;
  logic [FLAG_W-1:0] s2_hi_f, s2_lo_f, s2_d_f;
  logic              s2_inv;

  always_ff @(posedge clk) begin
    if (v_q[0]) begin
      s2_res  <= res;
      s2_hi_f <= hi_f;
      s2_lo_f <= lo_f;
      s2_d_f  <= d_f;
      s2_inv  <= inv;
    end
  end

  // --------------------
  // stage 3 output
  fpu_word_u         o_res;
  logic [FLAG_W-1:0] o_hi_f, o_lo_f, o_d_f;
  logic              o_inv;

  if (PIPE_OUT_REG != 0) begin : g_out_reg
    always_ff @(posedge clk) begin
      if (v_q[1]) begin
        o_res  <= s2_res;
        o_hi_f <= s2_hi_f;
        o_lo_f <= s2_lo_f;
        o_d_f  <= s2_d_f;
        o_inv  <= s2_inv;
      end
    end
  end else begin : g_out_comb
    assign o_res  = s2_res;
    assign o_hi_f = s2_hi_f;
    assign o_lo_f = s2_lo_f;
    assign o_d_f  = s2_d_f;
    assign o_inv  = s2_inv;
  end

  assign out_valid   = v_q[DEPTH-1];
  assign out_invalid = v_q[DEPTH-1] && o_inv;
  assign out_data    = o_res;

  // flag source follows the opcode at the output stage
  always_comb begin
    case (op_q[DEPTH-1])
      OP_CMP_S: out_flags = {o_hi_f, o_lo_f};
      OP_CMP_D: out_flags = {{FLAG_W{1'b0}}, o_d_f};
      default:  out_flags = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/fpu_exc_acc.sv ====
// fpu invalid status accumulator
`timescale 1ns/100ps
`default_nettype none

module fpu_exc_acc #(
  parameter int unsigned CNT_W = 16
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             res_valid,
  input  logic             res_invalid,
  input  logic             clr,
  output logic             sticky,
  output logic [CNT_W-1:0] count
);

  logic hit;
  logic cnt_full;

  // --------------------
  // event decode
  assign hit      = res_valid && res_invalid;
  assign cnt_full = &count;  // counter holds at all ones.

  // --------------------
  // status registers
  always_ff @(posedge clk) begin
    if (rst || clr) begin
      sticky <= 1'b0;
      count  <= '0;
    end else if (hit) begin
      sticky <= 1'b1;
      if (!cnt_full) begin
        count <= count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/fpu_lane.sv ====
// fpu compare lane
`timescale 1ns/100ps
`default_nettype none

module fpu_lane #(
  parameter bit HIGH = 1'b0
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       in_valid,
  input  fpu_pkg::fpu_op_e           in_op,
  input  logic [fpu_pkg::LANE_W-1:0] a,
  input  logic [fpu_pkg::LANE_W-1:0] b,
  input  logic                       lo_frac_nz_a,
  input  logic                       lo_frac_nz_b,
  output logic                       lane_frac_nz_a,
  output logic                       lane_frac_nz_b,
  output logic                       st_mag_lt,
  output logic                       st_mag_eq,
  output logic                       st_sign_a,
  output logic                       st_sign_b,
  output logic                       st_nan_a,
  output logic                       st_nan_b,
  output logic                       st_zero_a,
  output logic                       st_zero_b,
  output logic                       st_dnan_a,
  output logic                       st_dnan_b,
  output logic                       st_dzero_a,
  output logic                       st_dzero_b,
  output logic [fpu_pkg::LANE_W-1:0] st_res
);
  import fpu_pkg::*;

  logic              wide;
  logic [LANE_W-1:0] mag_a;
  logic [LANE_W-1:0] mag_b;
  logic              nan_a;
  logic              nan_b;
  logic              zero_a;
  logic              zero_b;
  logic              dfrac_a;
  logic              dfrac_b;
  logic              dnan_a;
  logic              dnan_b;
  logic              dzero_a;
  logic              dzero_b;
  logic [LANE_W-1:0] res;

  // --------------------
  // magnitude compare
  // the low half of a double is pure fraction, so it compares all 32 bits
  assign wide  = !HIGH && (in_op inside {OP_MAX_D, OP_MIN_D, OP_CMP_D});
  assign mag_a = wide ? a : {1'b0, a[LANE_W-2:0]};
  assign mag_b = wide ? b : {1'b0, b[LANE_W-2:0]};

  // --------------------
  // single decode
  assign nan_a  = (&a[30:23]) && (|a[22:0]);  // exp all ones, frac nonzero.
  assign nan_b  = (&b[30:23]) && (|b[22:0]);
  assign zero_a = ~|a[LANE_W-2:0];
  assign zero_b = ~|b[LANE_W-2:0];

  // --------------------
  // double decode
  assign dfrac_a = HIGH ? |a[19:0] : |a;  // double fraction bits held here.
  assign dfrac_b = HIGH ? |b[19:0] : |b;

  assign lane_frac_nz_a = dfrac_a;
  assign lane_frac_nz_b = dfrac_b;

  assign dnan_a  = HIGH && (&a[30:20]) && (dfrac_a || lo_frac_nz_a);
  assign dnan_b  = HIGH && (&b[30:20]) && (dfrac_b || lo_frac_nz_b);
  assign dzero_a = HIGH && zero_a && !lo_frac_nz_a;
  assign dzero_b = HIGH && zero_b && !lo_frac_nz_b;

  // --------------------
  // lane result
  always_comb begin
    res = '0;
    case (in_op)
      OP_ABS: res = {1'b0, a[LANE_W-2:0]};
      OP_NEG: res = {~a[LANE_W-1], a[LANE_W-2:0]};
      OP_MAX_S, OP_MIN_S: begin
        if (nan_a && nan_b) begin
          res = QNAN_S;  // otherwise the stage after picks a or b.
        end
      end
      default: res = '0;
    endcase
  end

  // stage 1 register
  always_ff @(posedge clk) begin
    if (rst) begin
      st_mag_lt  <= 1'b0;
      st_mag_eq  <= 1'b0;
      st_sign_a  <= 1'b0;
      st_sign_b  <= 1'b0;
      st_nan_a   <= 1'b0;
      st_nan_b   <= 1'b0;
      st_zero_a  <= 1'b0;
      st_zero_b  <= 1'b0;
      st_dnan_a  <= 1'b0;
      st_dnan_b  <= 1'b0;
      st_dzero_a <= 1'b0;
      st_dzero_b <= 1'b0;
    end else if (in_valid) begin
      st_mag_lt  <= mag_a < mag_b;
      st_mag_eq  <= mag_a == mag_b;
      st_sign_a  <= a[LANE_W-1];
      st_sign_b  <= b[LANE_W-1];
      st_nan_a   <= nan_a;
      st_nan_b   <= nan_b;
      st_zero_a  <= zero_a;
      st_zero_b  <= zero_b;
      st_dnan_a  <= dnan_a;
      st_dnan_b  <= dnan_b;
      st_dzero_a <= dzero_a;
      st_dzero_b <= dzero_b;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      st_res <= res;
    end
  end

endmodule

`default_nettype wire

// ==== source/fpu_pkg.sv ====
// fpu compare definitions
`default_nettype none

package fpu_pkg;

  // --------------------
  // widths
  localparam int LANE_W = 32;
  localparam int FLAG_W = 4;

  // bit positions inside one lane's flag vector.
  localparam int FLG_LT = 3;
  localparam int FLG_EQ = 2;
  localparam int FLG_GT = 1;
  localparam int FLG_UO = 0;

  // canonical quiet NaNs.
  localparam logic [LANE_W-1:0]   QNAN_S = 32'h7fc0_0000;
  localparam logic [2*LANE_W-1:0] QNAN_D = 64'h7ff8_0000_0000_0000;

  // --------------------
  // opcodes
  // codes 0 and 9..15 fall through as no operation
  typedef enum logic [3:0] {
    OP_MAX_S = 4'h1,
    OP_MIN_S = 4'h2,
    OP_CMP_S = 4'h3,
    OP_ABS   = 4'h4,
    OP_NEG   = 4'h5,
    OP_MAX_D = 4'h6,
    OP_MIN_D = 4'h7,
    OP_CMP_D = 4'h8
  } fpu_op_e;

  // --------------------
  // operand word
  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] frac;
  } fpu_single_t;

  typedef struct packed {
    logic        sign;
    logic [10:0] exp;
    logic [51:0] frac;
  } fpu_double_t;

  // one 64-bit register seen as two singles or as one double.
  typedef union packed {
    struct packed {
      fpu_single_t hi;  // bits 63..32.
      fpu_single_t lo;  // bits 31..0.
    } s;
    fpu_double_t d;
  } fpu_word_u;

endpackage

`default_nettype wire

// ==== source/fpu_top.sv ====
// fpu compare unit top
`timescale 1ns/100ps
`default_nettype none

module fpu_top #(
  parameter int unsigned PIPE_OUT_REG = 1,
  parameter int unsigned CNT_W        = 16
) (
  input  logic                         clk,
  input  logic                         rst,
  // issue side
  input  logic                         in_valid,
  input  fpu_pkg::fpu_op_e             in_op,
  input  logic [63:0]                  in_a,
  input  logic [63:0]                  in_b,
  // return side
  output logic                         out_valid,
  output logic [63:0]                  out_data,
  output logic [2*fpu_pkg::FLAG_W-1:0] out_flags,
  output logic                         out_invalid,
  // exception status
  input  logic                         exc_clr,
  output logic                         exc_sticky,
  output logic [CNT_W-1:0]             exc_count
);

  // --------------------
  // datapath
  fpu_both #(
    .PIPE_OUT_REG(PIPE_OUT_REG)
  ) both0 (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_op      (in_op),
    .in_a       (in_a),
    .in_b       (in_b),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_flags  (out_flags),
    .out_invalid(out_invalid)
  );

  // --------------------
  // invalid status
  fpu_exc_acc #(
    .CNT_W(CNT_W)
  ) exc0 (
    .clk        (clk),
    .rst        (rst),
    .res_valid  (out_valid),
    .res_invalid(out_invalid),  // already qualified by out_valid.
    .clr        (exc_clr),
    .sticky     (exc_sticky),
    .count      (exc_count)
  );

endmodule

`default_nettype wire

// ==== tb/fpu_tb_vectors.svh ====
// fpu directed vectors
`ifndef FPU_TB_VECTORS_SVH
`define FPU_TB_VECTORS_SVH

// columns are op, a, b, expected data, expected flags, expected invalid
// flags per lane read lt, eq, gt, unordered
task automatic fill_table();
  // --------------------
  // single ordering
  add_row(OP_MAX_S, 64'h3f800000bf800000, 64'h40000000c0000000, 64'h40000000bf800000, 8'h00, 1'b0);
  add_row(OP_MIN_S, 64'h3f800000bf800000, 64'h40000000c0000000, 64'h3f800000c0000000, 8'h00, 1'b0);
  add_row(OP_CMP_S, 64'h3f800000bf800000, 64'h40000000c0000000, 64'h0000000000000000, 8'h82, 1'b0);
  add_row(OP_CMP_S, 64'h8000000040400000, 64'h0000000040400000, 64'h0000000000000000, 8'h44, 1'b0);
  add_row(OP_MAX_S, 64'h8000000040400000, 64'h0000000040400000, 64'h0000000040400000, 8'h00, 1'b0);
  add_row(OP_MIN_S, 64'h00000000bf800000, 64'h800000003f000000, 64'h80000000bf800000, 8'h00, 1'b0);
  add_row(OP_CMP_S, 64'h7f800000c0000000, 64'h3f800000bf800000, 64'h0000000000000000, 8'h28, 1'b0);
  add_row(OP_MAX_S, 64'h7f80000000000001, 64'h7f7fffff80000001, 64'h7f80000000000001, 8'h00, 1'b0);
  add_row(OP_CMP_S, 64'h7f8000007f800000, 64'h7f800000ff800000, 64'h0000000000000000, 8'h42, 1'b0);
  // --------------------
  // single NaN
  add_row(OP_MAX_S, 64'h7fc000003f800000, 64'h400000007f800001, 64'h400000003f800000, 8'h00, 1'b1);
  add_row(OP_MIN_S, 64'h7fc000003f800000, 64'hffc0000140000000, 64'h7fc000003f800000, 8'h00, 1'b1);
  add_row(OP_CMP_S, 64'h7fc000003f800000, 64'h3f8000003f800000, 64'h0000000000000000, 8'h14, 1'b1);
  // --------------------
  // double ordering and NaN
  add_row(OP_MAX_D, 64'h3ff0000000000001, 64'h3ff0000000000002, 64'h3ff0000000000002, 8'h00, 1'b0);
  add_row(OP_MIN_D, 64'h3ff0000000000001, 64'h3ff0000000000002, 64'h3ff0000000000001, 8'h00, 1'b0);
  add_row(OP_CMP_D, 64'h3ff0000000000001, 64'h3ff0000000000002, 64'h0000000000000000, 8'h08, 1'b0);
  add_row(OP_CMP_D, 64'hbff0000000000001, 64'hbff0000000000002, 64'h0000000000000000, 8'h02, 1'b0);
  add_row(OP_MAX_D, 64'hbff0000000000001, 64'hbff0000000000002, 64'hbff0000000000001, 8'h00, 1'b0);
  add_row(OP_MAX_D, 64'hc000000000000000, 64'h3ff0000000000000, 64'h3ff0000000000000, 8'h00, 1'b0);
  add_row(OP_MIN_D, 64'h0000000000000000, 64'h8000000000000000, 64'h8000000000000000, 8'h00, 1'b0);
  add_row(OP_CMP_D, 64'h0000000000000000, 64'h8000000000000000, 64'h0000000000000000, 8'h04, 1'b0);
  add_row(OP_CMP_D, 64'h7ff0000000000000, 64'h7ff0000000000000, 64'h0000000000000000, 8'h04, 1'b0);
  add_row(OP_CMP_D, 64'h7ff0000000000001, 64'h3ff0000000000000, 64'h0000000000000000, 8'h01, 1'b1);
  add_row(OP_MAX_D, 64'h7ff0000000000001, 64'h4000000000000000, 64'h4000000000000000, 8'h00, 1'b1);
  add_row(OP_MIN_D, 64'hfff0000080000000, 64'h7ff0000000000001, 64'h7ff8000000000000, 8'h00, 1'b1);
  // --------------------
  // sign ops and no operation
  add_row(OP_ABS, 64'hbf8000007fc00001, 64'hffffffffffffffff, 64'h3f8000007fc00001, 8'h00, 1'b0);
  add_row(OP_NEG, 64'h3f800000ffc00000, 64'h0000000000000000, 64'hbf8000007fc00000, 8'h00, 1'b0);
  add_row(OP_NEG, 64'h8000000000000000, 64'h0000000000000000, 64'h0000000080000000, 8'h00, 1'b0);
  add_row(fpu_op_e'(0), 64'h7fc000007fc00000, 64'h7fc000007fc00000,
          64'h0000000000000000, 8'h00, 1'b0);
endtask

`endif

// ==== tb/fpu_tb.sv ====
// fpu compare unit testbench
`timescale 1ns/100ps
`default_nettype none

module fpu_tb;
  import fpu_pkg::*;

  localparam int NUM_RAND = 300;

  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  flags;
    logic        inv;
  } exp_t;

  typedef struct packed {
    fpu_op_e     op;
    logic [63:0] a;
    logic [63:0] b;
    exp_t        e;
  } row_t;

  logic        clk = 1'b0;
  logic        rst;
  logic        in_valid;
  fpu_op_e     in_op;
  logic [63:0] in_a;
  logic [63:0] in_b;
  logic        out_valid;
  logic [63:0] out_data;
  logic [7:0]  out_flags;
  logic        out_invalid;
  logic        exc_clr;
  logic        exc_sticky;
  logic [15:0] exc_count;

  row_t        table_q[$];
  exp_t        exp_q[$];
  logic [31:0] lfsr = 32'h0d93_e821;
  int          errors = 0;
  int          inv_count = 0;
  int          cycles = 0;
  int          limit = 0;
  logic        track_exc = 1'b0;

  fpu_top #(.PIPE_OUT_REG(1), .CNT_W(16)) dut0 (
    .clk(clk), .rst(rst), .in_valid(in_valid), .in_op(in_op), .in_a(in_a), .in_b(in_b),
    .out_valid(out_valid), .out_data(out_data), .out_flags(out_flags),
    .out_invalid(out_invalid), .exc_clr(exc_clr), .exc_sticky(exc_sticky),
    .exc_count(exc_count)
  );

  always #2 clk = ~clk;

  // --------------------
  // run control
  task automatic abort_run();
    $display("Test failures found");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] want);
    if (got !== want) begin
      errors++;
      $display("** Error at %0t ns: %s = %0h, expected %0h", $time, name, got, want);
      abort_run();
    end
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32, 22, 2, 1.
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[62:0], lfsr[0]};
    end
  endtask

  task automatic add_row(input fpu_op_e op, input logic [63:0] a, input logic [63:0] b,
                         input logic [63:0] data, input logic [7:0] flags, input logic inv);
    row_t r;
    r.op = op;
    r.a = a;
    r.b = b;
    r.e.data = data;
    r.e.flags = flags;
    r.e.inv = inv;
    table_q.push_back(r);
  endtask

  `include "fpu_tb_vectors.svh"

  // --------------------
  // reference model
  // -1 less, 0 equal, 1 greater, 2 unordered.
  function automatic int order_of(input logic nan_a, input logic nan_b, input logic zero_a,
                                  input logic zero_b, input logic sign_a, input logic sign_b,
                                  input logic [62:0] mag_a, input logic [62:0] mag_b,
                                  input logic signed_zero);
    if (nan_a || nan_b) return 2;
    if (zero_a && zero_b) begin
      if (!signed_zero || sign_a == sign_b) return 0;
      return sign_a ? -1 : 1;
    end
    if (sign_a != sign_b) return sign_a ? -1 : 1;
    if (mag_a == mag_b) return 0;
    return ((mag_a < mag_b) != sign_a) ? -1 : 1;
  endfunction

  function automatic logic [3:0] flags_of(input int ord);
    if (ord < 0) return 4'b1000;
    if (ord == 0) return 4'b0100;
    if (ord == 1) return 4'b0010;
    return 4'b0001;
  endfunction

  function automatic logic [63:0] pick(input int ord, input logic nan_a, input logic nan_b,
                                       input logic [63:0] a, input logic [63:0] b,
                                       input logic [63:0] qnan, input logic want_max);
    if (nan_a && nan_b) return qnan;
    if (nan_a) return b;
    if (nan_b) return a;
    if (want_max) return (ord < 0) ? b : a;
    return (ord > 0) ? b : a;
  endfunction

  task automatic single_lane(input fpu_single_t a, input fpu_single_t b, input logic want_max,
                             output logic [31:0] res, output logic [3:0] f, output logic nan);
    logic        na, nb, za, zb;
    logic [63:0] wide;
    na = (a.exp == 8'hff) && (a.frac != 0);
    nb = (b.exp == 8'hff) && (b.frac != 0);
    za = (a.exp == 0) && (a.frac == 0);
    zb = (b.exp == 0) && (b.frac == 0);
    f = flags_of(order_of(na, nb, za, zb, a.sign, b.sign, {32'b0, a.exp, a.frac},
                          {32'b0, b.exp, b.frac}, 1'b0));
    wide = pick(order_of(na, nb, za, zb, a.sign, b.sign, {32'b0, a.exp, a.frac},
                         {32'b0, b.exp, b.frac}, 1'b1),
                na, nb, {32'b0, a}, {32'b0, b}, {32'b0, QNAN_S}, want_max);
    res = wide[31:0];
    nan = na || nb;
  endtask

  task automatic double_word(input fpu_double_t a, input fpu_double_t b, input logic want_max,
                             output logic [63:0] res, output logic [3:0] f, output logic nan);
    logic na, nb, za, zb;
    na = (a.exp == 11'h7ff) && (a.frac != 0);
    nb = (b.exp == 11'h7ff) && (b.frac != 0);
    za = (a.exp == 0) && (a.frac == 0);
    zb = (b.exp == 0) && (b.frac == 0);
    f = flags_of(order_of(na, nb, za, zb, a.sign, b.sign, {a.exp, a.frac}, {b.exp, b.frac}, 1'b0));
    res = pick(order_of(na, nb, za, zb, a.sign, b.sign, {a.exp, a.frac}, {b.exp, b.frac}, 1'b1),
               na, nb, a, b, QNAN_D, want_max);
    nan = na || nb;
  endtask

  task automatic predict(input fpu_op_e op, input fpu_word_u a, input fpu_word_u b,
                         output exp_t e);
    fpu_word_u   d;
    logic [31:0] rh, rl;
    logic [63:0] rd;
    logic [3:0]  fh, fl, fd;
    logic        nh, nl, nd, want_max;
    d = '0;
    e = '0;
    want_max = (op == OP_MAX_S) || (op == OP_MAX_D);
    single_lane(a.s.hi, b.s.hi, want_max, rh, fh, nh);
    single_lane(a.s.lo, b.s.lo, want_max, rl, fl, nl);
    double_word(a.d, b.d, want_max, rd, fd, nd);
    case (op)
      OP_ABS: begin
        d = a;
        d.s.hi.sign = 1'b0;
        d.s.lo.sign = 1'b0;
      end
      OP_NEG: begin
        d = a;
        d.s.hi.sign = !a.s.hi.sign;
        d.s.lo.sign = !a.s.lo.sign;
      end
      OP_MAX_S, OP_MIN_S: begin
        d.s.hi = rh;
        d.s.lo = rl;
        e.inv = nh || nl;
      end
      OP_CMP_S: begin
        e.flags = {fh, fl};
        e.inv = nh || nl;
      end
      OP_MAX_D, OP_MIN_D: begin
        d.d = rd;
        e.inv = nd;
      end
      OP_CMP_D: begin
        e.flags = {4'b0000, fd};
        e.inv = nd;
      end
      default: e.inv = 1'b0;  // no operation.
    endcase
    e.data = d;
  endtask

  // --------------------
  // issue and scoreboard
  task automatic issue(input fpu_op_e op, input logic [63:0] a, input logic [63:0] b,
                       input exp_t e);
    exp_q.push_back(e);
    in_valid = 1'b1;
    in_op = op;
    in_a = a;
    in_b = b;
    @(posedge clk);
    #1;
  endtask

  always @(negedge clk) begin : scoreboard
    exp_t e;
    if (!rst) begin
      if (track_exc) begin
        check("exc_sticky", exc_sticky, inv_count != 0);  // status lags results by one cycle.
        check("exc_count", exc_count, inv_count);
      end
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          $display("** Error at %0t ns: out_valid rose with no operation outstanding", $time);
          abort_run();
        end else begin
          e = exp_q.pop_front();
          check("out_data", out_data, e.data);
          check("out_flags", out_flags, e.flags);
          check("out_invalid", out_invalid, e.inv);
          if (e.inv) begin
            inv_count++;
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    if (!rst) begin
      cycles++;
      if (cycles > limit) begin
        $display("** Error at %0t ns: results stopped arriving within %0d cycles", $time, limit);
        abort_run();
      end
    end
  end

  // --------------------
  // main sequence
  initial begin : main
    exp_t        e;
    logic [63:0] v, a, b;
    logic [3:0]  op_raw;
    fpu_op_e     op;
    rst = 1'b1;
    in_valid = 1'b0;
    in_op = fpu_op_e'(0);
    in_a = '0;
    in_b = '0;
    exc_clr = 1'b0;
    fill_table();
    limit = table_q.size() + NUM_RAND + 20;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    check("out_valid", out_valid, 1'b0);
    check("out_invalid", out_invalid, 1'b0);
    check("exc_sticky", exc_sticky, 1'b0);
    check("exc_count", exc_count, 0);
    track_exc = 1'b1;

    foreach (table_q[i]) begin
      issue(table_q[i].op, table_q[i].a, table_q[i].b, table_q[i].e);
    end

    for (int i = 0; i < NUM_RAND; i++) begin
      take_bits(3, v);
      op_raw = {1'b0, v[2:0]} + 4'd1;
      op = fpu_op_e'(op_raw);
      take_bits(64, a);
      take_bits(64, b);
      take_bits(2, v);
      case (v[1:0])
        2'd0: begin
          take_bits(32, v);
          b = {a[63:32], v[31:0]};  // equal high halves.
        end
        2'd1: begin
          a[62:52] = '1;
          a[30:23] = '1;
        end
        2'd2: begin
          take_bits(1, v);
          a = a & (v[0] ? 64'h8000_0000_0000_0000 : 64'h8000_0000_8000_0000);
          b = b & (v[0] ? 64'h8000_0000_0000_0000 : 64'h8000_0000_8000_0000);
        end
        default: ;
      endcase
      predict(op, a, b, e);
      issue(op, a, b, e);
    end
    in_valid = 1'b0;

    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    @(posedge clk);
    #1;
    check("exc_sticky", exc_sticky, inv_count != 0);
    check("exc_count", exc_count, inv_count);

    track_exc = 1'b0;
    exc_clr = 1'b1;
    @(posedge clk);
    #1;
    exc_clr = 1'b0;
    check("exc_sticky", exc_sticky, 1'b0);
    check("exc_count", exc_count, 0);

    if (errors == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

`default_nettype wire
